//--- sources.f
design/wb_mem_pkg.sv
design/wb_sram16.sv
design/wb_mem_decode.sv
design/wb_mem_regs.sv
design/wb_mem_top.sv
tb/wb_mem_asserts.sv
tb/tb_wb_mem.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --assert -j 0
TOP       := tb_wb_mem
FILELIST  := sources.f
OBJ_DIR   := obj_dir

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- tb/tb_wb_mem.sv
`timescale 1ns/10ps

module tb_wb_mem;

  localparam int ADDR_BITS = 17;
  localparam int AW        = ADDR_BITS - 1;  // master word address
  localparam int WA        = ADDR_BITS - 2;  // sram word address
  localparam int TIMEOUT   = 20;
  localparam logic [AW-1:0] REG_BASE = {1'b1, {(AW-1){1'b0}}};

  logic          clk_i = 1'b0;
  logic          rst_i;
  logic          cyc_i;
  logic          stb_i;
  logic          we_i;
  logic [AW-1:0] adr_i;
  logic [3:0]    sel_i;
  logic [31:0]   dat_i;
  logic [31:0]   dat_o;
  logic          ack_o;
  logic          err_o;
  logic [AW-1:0] sram_addr_o;
  logic [15:0]   sram_dat_o;
  logic [15:0]   sram_dat_i;
  logic          sram_we_n_o;
  logic          sram_oe_n_o;
  logic          sram_lb_n_o;
  logic          sram_ub_n_o;

  logic [15:0] sram_mem [0:(1 << AW) - 1];
  logic [7:0]  shadow [0:(1 << ADDR_BITS) - 1];  // expected sram contents by byte
  logic [31:0] lfsr_state;
  int          xfer_count;  // sram acks so far
  int          err_count;

  always #4 clk_i = ~clk_i;

  wb_mem_top #(.ADDR_BITS(ADDR_BITS)) i_wb_mem_top (.*);

  // the async sram write lands at the end of the we low cycle
  always @(posedge clk_i) begin
    if (!sram_we_n_o) begin
      if (!sram_lb_n_o) sram_mem[sram_addr_o][7:0] = sram_dat_o[7:0];
      if (!sram_ub_n_o) sram_mem[sram_addr_o][15:8] = sram_dat_o[15:8];
    end
  end
  // combinational read, the bus floats while oe is high
  assign sram_dat_i = sram_oe_n_o ? 16'hxxxx : sram_mem[sram_addr_o];

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v          = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [AW-1:0] reg_addr(input logic [1:0] idx);
    return REG_BASE + AW'(idx);
  endfunction

  task automatic expect_equal(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  // one wishbone cycle that checks the response kind and its latency
  task automatic bus_access(input logic write, input logic [AW-1:0] addr,
                            input logic [3:0] bsel, input logic [31:0] wd,
                            input logic exp_err, output logic [31:0] rd);
    int lat;
    cyc_i = 1'b1;
    stb_i = 1'b1;
    we_i  = write;
    adr_i = addr;
    sel_i = bsel;
    dat_i = wd;
    lat   = 0;
    while (!ack_o && !err_o && lat < TIMEOUT) begin
      @(posedge clk_i);
      #1;
      lat++;
    end
    if (!ack_o && !err_o) begin
      $display("no ack or err from the DUT within %0d cycles at %0t", TIMEOUT, $time);
      $display("Something failed");
      $fatal(1);
    end
    rd = dat_o;
    expect_equal(32'(err_o), 32'(exp_err), "response kind");
    // sram words take two halfword phases, everything else answers at once
    expect_equal(lat, (bsel == 4'hf && !addr[AW-1] && !exp_err) ? 2 : 1, "latency");
    if (err_o) err_count++;
    else if (!addr[AW-1]) xfer_count++;
    cyc_i = 1'b0;
    stb_i = 1'b0;
    @(posedge clk_i);  // response pulse ends
    #1;
  endtask

  // writes take fresh lfsr data, reads are compared with the shadow
  task automatic sram_access(input logic write, input logic [WA-1:0] waddr,
                             input logic [3:0] bsel, input string what);
    logic [31:0] wd;
    logic [31:0] rd;
    logic [31:0] exp;
    wd  = rand_bits(32);
    exp = '0;
    bus_access(write, {1'b0, waddr}, bsel, wd, 1'b0, rd);
    for (int b = 0; b < 4; b++) begin
      if (bsel[b] && write) shadow[{waddr, 2'(b)}] = wd[8*b +: 8];
      if (bsel[b]) exp[8*b +: 8] = shadow[{waddr, 2'(b)}];  // other lanes read zero
    end
    if (!write) expect_equal(rd, exp, what);
  endtask

  initial begin
    logic [WA-1:0] waddrs [8];
    logic [WA-1:0] wa;
    logic [31:0]   rd;
    logic [31:0]   word;
    rst_i      = 1'b1;
    cyc_i      = 1'b0;
    stb_i      = 1'b0;
    we_i       = 1'b0;
    adr_i      = '0;
    sel_i      = '0;
    dat_i      = '0;
    lfsr_state = 32'h0f3f5f05;
    xfer_count = 0;
    err_count  = 0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    // random words are read back once all are written
    for (int i = 0; i < 8; i++) begin
      waddrs[i] = WA'(rand_bits(WA));
      sram_access(1'b1, waddrs[i], 4'hf, "");
    end
    for (int i = 0; i < 8; i++) sram_access(1'b0, waddrs[i], 4'hf, "word read back");

    // byte lanes merge into one word
    wa = WA'(rand_bits(WA));
    sram_access(1'b1, wa, 4'hf, "");
    for (int b = 0; b < 4; b++) begin
      sram_access(1'b1, wa, 4'(1 << b), "");
      sram_access(1'b0, wa, 4'hf, "word after byte write");
      sram_access(1'b0, wa, 4'(1 << b), "byte read");
    end

    wa = WA'(rand_bits(WA));
    sram_access(1'b1, wa, 4'hf, "");
    sram_access(1'b1, wa, 4'b1100, "");
    sram_access(1'b0, wa, 4'hf, "word after upper half write");
    sram_access(1'b1, wa, 4'b0011, "");
    sram_access(1'b0, wa, 4'hf, "word after lower half write");
    sram_access(1'b0, wa, 4'b0011, "lower half read");
    sram_access(1'b0, wa, 4'b1100, "upper half read");

    // scattered or empty selects are refused and leave the word alone
    bus_access(1'b1, {1'b0, wa}, 4'b0101, rand_bits(32), 1'b1, rd);
    bus_access(1'b0, {1'b0, wa}, 4'b0000, 32'h0, 1'b1, rd);
    sram_access(1'b0, wa, 4'hf, "word after illegal sel");

    // register page holes, read-only register, partial select
    bus_access(1'b0, REG_BASE + AW'(4), 4'hf, 32'h0, 1'b1, rd);
    bus_access(1'b1, reg_addr(wb_mem_pkg::REG_ID), 4'hf, rand_bits(32), 1'b1, rd);
    bus_access(1'b1, reg_addr(wb_mem_pkg::REG_SCRATCH), 4'b0011, rand_bits(32), 1'b1, rd);
    bus_access(1'b0, reg_addr(wb_mem_pkg::REG_SCRATCH), 4'hf, 32'h0, 1'b0, rd);
    expect_equal(rd, 32'h0, "scratch after refused write");

    word = rand_bits(32);
    bus_access(1'b1, reg_addr(wb_mem_pkg::REG_SCRATCH), 4'hf, word, 1'b0, rd);
    bus_access(1'b0, reg_addr(wb_mem_pkg::REG_SCRATCH), 4'hf, 32'h0, 1'b0, rd);
    expect_equal(rd, word, "scratch read back");
    bus_access(1'b0, reg_addr(wb_mem_pkg::REG_ID), 4'hf, 32'h0, 1'b0, rd);
    expect_equal(rd, wb_mem_pkg::MEM_ID, "identity word");
    bus_access(1'b0, reg_addr(wb_mem_pkg::REG_XFER_CNT), 4'hf, 32'h0, 1'b0, rd);
    expect_equal(rd, 32'(xfer_count), "transfer counter");
    bus_access(1'b0, reg_addr(wb_mem_pkg::REG_ERR_CNT), 4'hf, 32'h0, 1'b0, rd);
    expect_equal(rd, 32'(err_count), "error counter");

    $display("Everything OK");
    $finish;
  end

endmodule

//--- tb/wb_mem_asserts.sv
`timescale 1ns/10ps

module wb_mem_asserts #(
  parameter int ADDR_BITS = 17
) (
  input logic                 clk_i,
  input logic                 rst_i,
  input logic                 cyc_i,
  input logic                 stb_i,
  input logic                 we_i,
  input logic [ADDR_BITS-2:0] adr_i,
  input logic                 ack_i,
  input logic                 err_i,
  input logic                 sram_we_n_i,
  input logic                 sram_oe_n_i
);

  logic req;
  logic sram_wr_req;  // write aimed at the sram half of the map

  assign req         = cyc_i & stb_i;
  assign sram_wr_req = req & we_i & ~adr_i[ADDR_BITS-2];

  ack_err_excl: assert property (@(posedge clk_i) disable iff (rst_i) !(ack_i && err_i))
    else $error("ack and err high together");

  resp_after_req: assert property (@(posedge clk_i) disable iff (rst_i)
    (ack_i || err_i) |-> ($past(req) || $past(req, 2)))
    else $error("response without a request in the two cycles before");

  // one strobe cycle per phase, each right after a phase was started
  we_after_write: assert property (@(posedge clk_i) disable iff (rst_i)
    !sram_we_n_i |-> $past(sram_wr_req))
    else $error("sram write strobe without a write request");

  we_oe_excl: assert property (@(posedge clk_i) disable iff (rst_i)
    !(!sram_we_n_i && !sram_oe_n_i))
    else $error("sram we and oe low together");

  quiet_in_reset: assert property (@(posedge clk_i)
    rst_i && $past(rst_i) |-> !ack_i && !err_i)
    else $error("response during reset");

endmodule

bind wb_mem_top wb_mem_asserts #(
  .ADDR_BITS (ADDR_BITS)
) i_wb_mem_asserts (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .cyc_i       (cyc_i),
  .stb_i       (stb_i),
  .we_i        (we_i),
  .adr_i       (adr_i),
  .ack_i       (ack_o),
  .err_i       (err_o),
  .sram_we_n_i (sram_we_n_o),
  .sram_oe_n_i (sram_oe_n_o)
);

//--- design/wb_mem_top.sv
`timescale 1ns/10ps

module wb_mem_top #(
  parameter int ADDR_BITS = 17  // sram byte address width
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  // wishbone master port
  input  logic                        cyc_i,
  input  logic                        stb_i,
  input  logic                        we_i,
  input  logic [ADDR_BITS-2:0]        adr_i,
  input  logic [3:0]                  sel_i,
  input  logic [wb_mem_pkg::XLEN-1:0] dat_i,
  output logic [wb_mem_pkg::XLEN-1:0] dat_o,
  output logic                        ack_o,
  output logic                        err_o,
  // sram pins, active low strobes
  output logic [ADDR_BITS-2:0]        sram_addr_o,
  output logic [15:0]                 sram_dat_o,
  input  logic [15:0]                 sram_dat_i,
  output logic                        sram_we_n_o,
  output logic                        sram_oe_n_o,
  output logic                        sram_lb_n_o,
  output logic                        sram_ub_n_o
);

  logic                        slv_we;
  logic [3:0]                  slv_sel;
  logic [wb_mem_pkg::XLEN-1:0] slv_wdat;

  logic                        brg_stb;
  logic [ADDR_BITS-3:0]        brg_adr;
  logic [wb_mem_pkg::XLEN-1:0] brg_rdat;
  logic                        brg_ack;
  logic                        brg_err;

  logic                        reg_stb;
  logic [1:0]                  reg_adr;
  logic [wb_mem_pkg::XLEN-1:0] reg_rdat;
  logic                        reg_ack;
  logic                        reg_err;

  logic                        ev_xfer;
  logic                        ev_err;

  wb_mem_decode #(
    .ADDR_BITS (ADDR_BITS)
  ) i_wb_mem_decode (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .cyc_i      (cyc_i),
    .stb_i      (stb_i),
    .we_i       (we_i),
    .adr_i      (adr_i),
    .sel_i      (sel_i),
    .dat_i      (dat_i),
    .dat_o      (dat_o),
    .ack_o      (ack_o),
    .err_o      (err_o),
    .slv_we_o   (slv_we),
    .slv_sel_o  (slv_sel),
    .slv_dat_o  (slv_wdat),
    .sram_stb_o (brg_stb),
    .sram_adr_o (brg_adr),
    .sram_dat_i (brg_rdat),
    .sram_ack_i (brg_ack),
    .sram_err_i (brg_err),
    .reg_stb_o  (reg_stb),
    .reg_adr_o  (reg_adr),
    .reg_dat_i  (reg_rdat),
    .reg_ack_i  (reg_ack),
    .reg_err_i  (reg_err),
    .ev_xfer_o  (ev_xfer),
    .ev_err_o   (ev_err)
  );

  wb_sram16 #(
    .ADDR_BITS (ADDR_BITS)
  ) i_wb_sram16 (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .stb_i       (brg_stb),
    .we_i        (slv_we),
    .adr_i       (brg_adr),
    .sel_i       (slv_sel),
    .dat_i       (slv_wdat),
    .dat_o       (brg_rdat),
    .ack_o       (brg_ack),
    .err_o       (brg_err),
    .sram_addr_o (sram_addr_o),
    .sram_dat_o  (sram_dat_o),
    .sram_dat_i  (sram_dat_i),
    .sram_we_n_o (sram_we_n_o),
    .sram_oe_n_o (sram_oe_n_o),
    .sram_lb_n_o (sram_lb_n_o),
    .sram_ub_n_o (sram_ub_n_o)
  );

  wb_mem_regs i_wb_mem_regs (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .stb_i     (reg_stb),
    .we_i      (slv_we),
    .adr_i     (reg_adr),
    .sel_i     (slv_sel),
    .dat_i     (slv_wdat),
    .dat_o     (reg_rdat),
    .ack_o     (reg_ack),
    .err_o     (reg_err),
    .ev_xfer_i (ev_xfer),
    .ev_err_i  (ev_err)
  );

endmodule

//--- design/wb_mem_regs.sv
`timescale 1ns/10ps

module wb_mem_regs (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        stb_i,
  input  logic                        we_i,
  input  logic [1:0]                  adr_i,
  input  logic [3:0]                  sel_i,
  input  logic [wb_mem_pkg::XLEN-1:0] dat_i,
  output logic [wb_mem_pkg::XLEN-1:0] dat_o,
  output logic                        ack_o,
  output logic                        err_o,
  input  logic                        ev_xfer_i,  // one pulse per sram ack
  input  logic                        ev_err_i    // one pulse per err response
);

  logic [wb_mem_pkg::XLEN-1:0] scratch;
  logic [wb_mem_pkg::XLEN-1:0] xfer_cnt;
  logic [wb_mem_pkg::XLEN-1:0] err_cnt;
  logic [wb_mem_pkg::XLEN-1:0] rd_data;
  logic                        start;
  logic                        bad;

  assign start = stb_i & ~ack_o & ~err_o;

  // full words only, and only scratch is writable
  assign bad = (sel_i != 4'b1111) | (we_i & (adr_i != wb_mem_pkg::REG_SCRATCH));

  always_comb begin
    case (adr_i)
      wb_mem_pkg::REG_SCRATCH:  rd_data = scratch;
      wb_mem_pkg::REG_XFER_CNT: rd_data = xfer_cnt;
      wb_mem_pkg::REG_ERR_CNT:  rd_data = err_cnt;
      default:                  rd_data = wb_mem_pkg::MEM_ID;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_o   <= 1'b0;
      err_o   <= 1'b0;
      scratch <= '0;
    end else begin
      ack_o <= start & ~bad;
      err_o <= start & bad;
      if (start && !bad && we_i) begin
        scratch <= dat_i;
      end
    end
  end

  // event counters, wrap silently
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      xfer_cnt <= '0;
      err_cnt  <= '0;
    end else begin
      if (ev_xfer_i) begin
        xfer_cnt <= xfer_cnt + 1'b1;
      end
      if (ev_err_i) begin
        err_cnt <= err_cnt + 1'b1;
      end
    end
  end

  // read data captured with the request, held through the ack cycle
  always_ff @(posedge clk_i) begin
    if (start && !bad && !we_i) begin
      dat_o <= rd_data;
    end
  end

endmodule

//--- design/wb_mem_decode.sv
`timescale 1ns/10ps

module wb_mem_decode #(
  parameter int ADDR_BITS = 17
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  // master side
  input  logic                        cyc_i,
  input  logic                        stb_i,
  input  logic                        we_i,
  input  logic [ADDR_BITS-2:0]        adr_i,      // word address
  input  logic [3:0]                  sel_i,
  input  logic [wb_mem_pkg::XLEN-1:0] dat_i,
  output logic [wb_mem_pkg::XLEN-1:0] dat_o,
  output logic                        ack_o,
  output logic                        err_o,
  // shared request lines to both slaves
  output logic                        slv_we_o,
  output logic [3:0]                  slv_sel_o,
  output logic [wb_mem_pkg::XLEN-1:0] slv_dat_o,
  // sram bridge
  output logic                        sram_stb_o,
  output logic [ADDR_BITS-3:0]        sram_adr_o,
  input  logic [wb_mem_pkg::XLEN-1:0] sram_dat_i,
  input  logic                        sram_ack_i,
  input  logic                        sram_err_i,
  // register page
  output logic                        reg_stb_o,
  output logic [1:0]                  reg_adr_o,
  input  logic [wb_mem_pkg::XLEN-1:0] reg_dat_i,
  input  logic                        reg_ack_i,
  input  logic                        reg_err_i,
  // events for the counters
  output logic                        ev_xfer_o,
  output logic                        ev_err_o
);

  logic req;
  logic in_sram;
  logic in_regs;
  logic unmapped;
  logic unmap_err;   // decoder's own error response

  assign req = cyc_i & stb_i;

  // top bit clear is sram, top bit set is the register page
  assign in_sram  = ~adr_i[ADDR_BITS-2];
  assign in_regs  = adr_i[ADDR_BITS-2] & (adr_i[ADDR_BITS-3:2] == '0);
  assign unmapped = ~in_sram & ~in_regs;

  assign sram_stb_o = req & in_sram;
  assign reg_stb_o  = req & in_regs;
  assign sram_adr_o = adr_i[ADDR_BITS-3:0];
  assign reg_adr_o  = adr_i[1:0];
  assign slv_we_o   = we_i;
  assign slv_sel_o  = sel_i;
  assign slv_dat_o  = dat_i;

  // one err pulse per unmapped request, the master still holds stb
  // during the pulse
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      unmap_err <= 1'b0;
    end else begin
      unmap_err <= req & unmapped & ~unmap_err;
    end
  end

  // read data from whichever slave the address points at
  always_comb begin
    if (in_sram) begin
      dat_o = sram_dat_i;
    end else if (in_regs) begin
      dat_o = reg_dat_i;
    end else begin
      dat_o = '0;
    end
  end

  // only the addressed slave can respond, so the responses just merge
  assign ack_o = sram_ack_i | reg_ack_i;
  assign err_o = sram_err_i | reg_err_i | unmap_err;

  assign ev_xfer_o = sram_ack_i;
  assign ev_err_o  = err_o;

endmodule

//--- design/wb_sram16.sv
`timescale 1ns/10ps

module wb_sram16 #(
  parameter int ADDR_BITS = 17
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        stb_i,
  input  logic                        we_i,
  input  logic [ADDR_BITS-3:0]        adr_i,       // word address
  input  logic [3:0]                  sel_i,
  input  logic [wb_mem_pkg::XLEN-1:0] dat_i,
  output logic [wb_mem_pkg::XLEN-1:0] dat_o,
  output logic                        ack_o,
  output logic                        err_o,
  output logic [ADDR_BITS-2:0]        sram_addr_o, // halfword address
  output logic [15:0]                 sram_dat_o,
  input  logic [15:0]                 sram_dat_i,
  output logic                        sram_we_n_o,
  output logic                        sram_oe_n_o,
  output logic                        sram_lb_n_o,
  output logic                        sram_ub_n_o
);

  wb_mem_pkg::req_size_e size;
  logic                        illegal;
  logic                        start;
  logic                        phase_hi;  // high halfword of a word still to go
  logic                        hi_half;   // byte or halfword sits in the upper halfword
  logic [1:0]                  byte_idx;
  logic [7:0]                  wr_byte;
  logic [15:0]                 wr_half;
  logic [15:0]                 lo_hold;   // low halfword of a word read
  logic [wb_mem_pkg::XLEN-1:0] lane_mask;

  // classify the byte selects
  always_comb begin
    illegal = 1'b0;
    case (sel_i)
      4'b0001, 4'b0010, 4'b0100, 4'b1000: size = wb_mem_pkg::BYTE;
      4'b0011, 4'b1100:                   size = wb_mem_pkg::HALF;
      4'b1111:                            size = wb_mem_pkg::WORD;
      default: begin
        // scattered lanes or no lanes at all
        size    = wb_mem_pkg::BYTE;
        illegal = 1'b1;
      end
    endcase
  end

  // a new request is taken only when idle and not answering the last one
  assign start = stb_i & ~ack_o & ~err_o & ~phase_hi;

  assign hi_half  = (size != wb_mem_pkg::WORD) & (sel_i[3] | sel_i[2]);
  assign byte_idx = {sel_i[3] | sel_i[2], sel_i[3] | sel_i[1]}; // one-hot to index
  assign wr_byte  = dat_i[{byte_idx, 3'b000} +: 8];

  // halfword put on the sram bus for the first (or only) phase
  always_comb begin
    case (size)
      wb_mem_pkg::BYTE: wr_half = {2{wr_byte}};  // lb/ub pick the lane
      wb_mem_pkg::HALF: wr_half = hi_half ? dat_i[31:16] : dat_i[15:0];
      default:          wr_half = dat_i[15:0];   // word, low halfword first
    endcase
  end

  assign lane_mask = {{8{sel_i[3]}}, {8{sel_i[2]}}, {8{sel_i[1]}}, {8{sel_i[0]}}};

  // read data is valid in the ack cycle, straight from the sram bus.
  // a halfword sits at its own lanes when repeated across both halves,
  // and so does a byte once the unselected lanes are masked off
  always_comb begin
    if (size == wb_mem_pkg::WORD) begin
      dat_o = {sram_dat_i, lo_hold};
    end else begin
      dat_o = {2{sram_dat_i}} & lane_mask;
    end
  end

  // control and strobes
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_o       <= 1'b0;
      err_o       <= 1'b0;
      phase_hi    <= 1'b0;
      sram_we_n_o <= 1'b1;
      sram_oe_n_o <= 1'b1;
    end else if (phase_hi) begin
      // second halfword of a word, ack goes out with it
      phase_hi    <= 1'b0;
      ack_o       <= 1'b1;
      err_o       <= 1'b0;
      sram_we_n_o <= ~we_i;
      sram_oe_n_o <= we_i;
    end else if (start && !illegal) begin
      phase_hi    <= (size == wb_mem_pkg::WORD);
      ack_o       <= (size != wb_mem_pkg::WORD);
      err_o       <= 1'b0;
      sram_we_n_o <= ~we_i;
      sram_oe_n_o <= we_i;
    end else begin
      ack_o       <= 1'b0;
      err_o       <= start & illegal; // bad sel, no sram cycle
      sram_we_n_o <= 1'b1;
      sram_oe_n_o <= 1'b1;
    end
  end

  // address, data and lane enables for each phase
  always_ff @(posedge clk_i) begin
    if (phase_hi) begin
      sram_addr_o[0] <= 1'b1;          // upper halfword of the word
      sram_dat_o     <= dat_i[31:16];
      if (!we_i) begin
        lo_hold <= sram_dat_i;         // low phase data still on the bus
      end
    end else if (start) begin
      sram_addr_o <= {adr_i, hi_half};
      sram_dat_o  <= wr_half;
      sram_lb_n_o <= ~(sel_i[0] | sel_i[2]);
      sram_ub_n_o <= ~(sel_i[1] | sel_i[3]);
    end
  end

endmodule

//--- design/wb_mem_pkg.sv
package wb_mem_pkg;

  // wishbone data width
  // the 16-bit sram split below is only written for 32
  localparam int XLEN = 32;

  // access size, decoded from the byte selects of a request
  typedef enum logic [1:0] {
    BYTE = 2'd0,  // one lane
    HALF = 2'd1,  // lanes 1:0 or 3:2
    WORD = 2'd2   // all four lanes, two sram cycles
  } req_size_e;

  // register page indices, low two bits of the page address
  localparam logic [1:0] REG_SCRATCH  = 2'd0; // read/write
  localparam logic [1:0] REG_XFER_CNT = 2'd1; // sram acks seen, read only
  localparam logic [1:0] REG_ERR_CNT  = 2'd2; // err responses, read only
  localparam logic [1:0] REG_ID       = 2'd3; // fixed identity, read only

  // identity word returned from REG_ID
  localparam logic [XLEN-1:0] MEM_ID = 32'h5753_3136;

endpackage
